// File: sim.f
src/speech_pkg.sv
src/speech_conditioner.sv
src/frame_window_buffer.sv
src/uart_frame_sender.sv
src/speech_frontend_top.sv
test/tb_speech_frontend.sv

// File: Makefile
# Verilator build and run for the speech front end testbench

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_speech_frontend \
		-Mdir obj_dir -o tb_sim

# run, keep the log, then pass only if the log holds the pass line
run: compile
	./obj_dir/tb_sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/frontend_cases.txt
# s <gap cycles> <code hex> sample after gap idle cycles, r <code hex> uses an lfsr gap
# e <0|1> sets tx_enable, w <cycles> waits, f <13 hex> is marker plus oldest..newest
r 000
r 000
r 000
r 000
r 040
r 040
r 080
r 080
r 020
r 020
r 020
r 060
f FF 80 80 80 80 90 80 90 80 68 80 80 90
s 140 060
s 140 060
s 140 0A0
s 140 0A0
f FF 90 80 90 80 68 80 80 90 80 80 90 81
s 140 0A0
s 140 000
s 140 000
s 140 040
f FF 68 80 80 90 80 80 90 81 81 59 7F 8F
# close spacing, the frame due at sample 24 is skipped
s 10 040
s 10 040
s 10 0C8
s 10 0C8
s 140 0C8
s 140 064
s 140 064
s 140 064
f FF 81 59 7F 8F 80 80 A2 81 81 68 80 80
# frame at sample 32 is held while disabled
e 0
s 20 064
s 20 028
s 20 028
s 20 028
s 20 028
s 20 0FA
s 20 0FA
w 300
f FF 80 80 A2 81 81 68 80 80 80 71 80 80
e 1

// File: test/tb_speech_frontend.sv
`timescale 1ns/1ns

module tb_speech_frontend;

	localparam int window         = 12;
	localparam int hop            = 4;
	localparam int cycles_per_bit = 4;
	localparam int frame_len      = window + 1;

	logic       clk_pixel;
	logic       sys_rst;
	logic [9:0] adc_code;
	logic       adc_valid;
	logic       tx_enable;
	logic       uart_tx;

	// parsed case file with one entry per command
	byte cmd_op[$];
	int  cmd_a[$];
	int  cmd_b[$];

	// bytes still owed by the DUT in arrival order
	logic [7:0] expect_q[$];

	logic [15:0] lfsr_state;
	int          cycle_count;
	int          cycle_limit;

	speech_frontend_top #(
		.window        (window),
		.hop           (hop),
		.cycles_per_bit(cycles_per_bit)
	) dut (
		.clk_pixel(clk_pixel),
		.sys_rst  (sys_rst),
		.adc_code (adc_code),
		.adc_valid(adc_valid),
		.tx_enable(tx_enable),
		.uart_tx  (uart_tx)
	);

	// 4 ns period
	always #2 clk_pixel = ~clk_pixel;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], fb};
	endfunction

	// four fresh bits give a gap of 1..16 cycles
	function automatic int random_gap();
		int gap;
		gap = 0;
		for (int i = 0; i < 4; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			gap = (gap << 1) | int'(lfsr_state[0]);
		end
		return gap + 1;
	endfunction

	// idle for gap cycles then a one cycle strobe
	task automatic send_sample(input int gap, input int code);
		repeat (gap) @(posedge clk_pixel);
		@(posedge clk_pixel);
		#1;
		adc_code  = 10'(code);
		adc_valid = 1'b1;
		@(posedge clk_pixel);
		#1;
		adc_valid = 1'b0;
	endtask

	// fills the command queues and sizes the timeout
	task automatic read_cases(output int limit);
		int    fd;
		int    n;
		int    gap;
		int    code;
		int    samples;
		int    bytes;
		int    max_gap;
		int    fb[frame_len];
		byte   op;
		string line;
		samples = 0;
		bytes   = 0;
		max_gap = 0;
		fd = $fopen("test/frontend_cases.txt", "r");
		if (fd == 0) begin
			abort_run("could not open test/frontend_cases.txt");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2) begin
				continue;
			end
			op = line.getc(0);
			if (op == "#") begin
				continue;
			end
			if (op == "r") begin
				n = $sscanf(line, "r %h", code);
				cmd_op.push_back(op);
				cmd_a.push_back(0);
				cmd_b.push_back(code);
				samples++;
				// widest lfsr gap
				if (max_gap < 16) begin
					max_gap = 16;
				end
			end else if (op == "s") begin
				n = $sscanf(line, "s %d %h", gap, code);
				cmd_op.push_back(op);
				cmd_a.push_back(gap);
				cmd_b.push_back(code);
				samples++;
				if (gap > max_gap) begin
					max_gap = gap;
				end
			end else if (op == "e" || op == "w") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%d", gap);
				cmd_op.push_back(op);
				cmd_a.push_back(gap);
				cmd_b.push_back(0);
				if (op == "w" && gap > max_gap) begin
					max_gap = gap;
				end
			end else if (op == "f") begin
				n = $sscanf(line, "f %h %h %h %h %h %h %h %h %h %h %h %h %h",
					fb[0], fb[1], fb[2], fb[3], fb[4], fb[5], fb[6],
					fb[7], fb[8], fb[9], fb[10], fb[11], fb[12]);
				if (n != frame_len) begin
					abort_run("frame line in case file is short");
				end
				// each frame byte becomes its own push command
				for (int i = 0; i < frame_len; i++) begin
					cmd_op.push_back(op);
					cmd_a.push_back(fb[i]);
					cmd_b.push_back(0);
				end
				bytes += frame_len;
			end else begin
				abort_run("unknown command in case file");
			end
		end
		$fclose(fd);
		limit = (samples * max_gap + bytes * 10 * cycles_per_bit) * 2;
	endtask

	// cycle budget counted from time zero
	always @(posedge clk_pixel) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			abort_run("timeout, the expected bytes did not all arrive in time");
		end
	end

	// line must sit idle while sending is disabled
	always @(negedge clk_pixel) begin
		if (!sys_rst && tx_enable == 1'b0) begin
			assert (uart_tx === 1'b1)
			else abort_run("uart_tx left idle while tx_enable was low");
		end
	end

	// uart receiver sampling near mid bit on falling clock edges
	initial begin : receiver
		logic [7:0] got;
		logic [7:0] want;
		wait (sys_rst === 1'b0);
		forever begin
			@(negedge clk_pixel);
			if (uart_tx === 1'b0) begin
				repeat (cycles_per_bit / 2 - 1) @(negedge clk_pixel);
				assert (uart_tx === 1'b0)
				else abort_run("start bit on uart_tx too short");
				for (int i = 0; i < 8; i++) begin
					repeat (cycles_per_bit) @(negedge clk_pixel);
					got[i] = uart_tx;
				end
				repeat (cycles_per_bit) @(negedge clk_pixel);
				assert (uart_tx === 1'b1)
				else abort_run("stop bit missing on uart_tx");
				assert (expect_q.size() != 0)
				else abort_run("byte on uart_tx when none was expected");
				want = expect_q.pop_front();
				assert (got === want)
				else abort_run($sformatf("[FAIL] uart_tx byte expected %02h got %02h",
					want, got));
			end
		end
	end

	initial begin
		clk_pixel   = 1'b0;
		sys_rst     = 1'b1;
		adc_code    = '0;
		adc_valid   = 1'b0;
		tx_enable   = 1'b1;
		lfsr_state  = 16'd7;
		cycle_count = 0;
		cycle_limit = 0;
		read_cases(cycle_limit);
		repeat (5) @(posedge clk_pixel);
		#1;
		sys_rst = 1'b0;
		for (int i = 0; i < cmd_op.size(); i++) begin
			case (cmd_op[i])
				"r": send_sample(random_gap(), cmd_b[i]);
				"s": send_sample(cmd_a[i], cmd_b[i]);
				"f": expect_q.push_back(8'(cmd_a[i]));
				"w": repeat (cmd_a[i]) @(posedge clk_pixel);
				"e": begin
					// drop enable only once the line has drained
					if (cmd_a[i] == 0) begin
						while (expect_q.size() != 0) begin
							@(posedge clk_pixel);
						end
					end
					@(posedge clk_pixel);
					#1;
					tx_enable = (cmd_a[i] != 0);
				end
				default: abort_run("bad command while running");
			endcase
		end
		while (expect_q.size() != 0) begin
			@(posedge clk_pixel);
		end
		// quiet tail where a stray byte would show up
		repeat (20 * cycles_per_bit) @(posedge clk_pixel);
		$display("Everything OK");
		$finish;
	end

endmodule

// File: src/speech_frontend_top.sv
`timescale 1ns/1ns

module speech_frontend_top #(
	parameter int window         = speech_pkg::default_window,
	parameter int hop            = speech_pkg::default_hop,
	parameter int cycles_per_bit = speech_pkg::default_cycles_per_bit
) (
	input  logic                            clk_pixel,
	input  logic                            sys_rst,
	input  logic [speech_pkg::adc_bits-1:0] adc_code,
	input  logic                            adc_valid,
	input  logic                            tx_enable,
	output logic                            uart_tx
);

	// conditioner to buffer
	speech_pkg::stream_byte_t emph_byte;
	logic                     emph_valid;

	// buffer to sender
	speech_pkg::stream_byte_t frame_byte;
	logic                     byte_ready;

	// sender back to buffer
	logic byte_take;

	// offset removal and pre-emphasis, 2 cycle latency
	speech_conditioner u_conditioner (
		.clk_pixel (clk_pixel),
		.sys_rst   (sys_rst),
		.adc_code  (adc_code),
		.adc_valid (adc_valid),
		.emph_byte (emph_byte),
		.emph_valid(emph_valid)
	);

	// sliding window store and frame readout
	frame_window_buffer #(
		.window(window),
		.hop   (hop)
	) u_window (
		.clk_pixel (clk_pixel),
		.sys_rst   (sys_rst),
		.emph_byte (emph_byte),
		.emph_valid(emph_valid),
		.byte_take (byte_take),
		.frame_byte(frame_byte),
		.byte_ready(byte_ready)
	);

	// 8N1 serial out
	uart_frame_sender #(
		.cycles_per_bit(cycles_per_bit)
	) u_sender (
		.clk_pixel (clk_pixel),
		.sys_rst   (sys_rst),
		.tx_enable (tx_enable),
		.frame_byte(frame_byte),
		.byte_ready(byte_ready),
		.byte_take (byte_take),
		.uart_tx   (uart_tx)
	);

endmodule

// File: src/uart_frame_sender.sv
`timescale 1ns/1ns

module uart_frame_sender #(
	parameter int cycles_per_bit = speech_pkg::default_cycles_per_bit
) (
	input  logic                     clk_pixel,
	input  logic                     sys_rst,
	input  logic                     tx_enable,
	input  speech_pkg::stream_byte_t frame_byte,
	input  logic                     byte_ready,
	output logic                     byte_take,
	output logic                     uart_tx
);

	localparam int cnt_bits = $clog2(cycles_per_bit + 1);
	localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(cycles_per_bit - 1);

	// index of the stop bit in the 10 bit frame
	localparam logic [3:0] stop_idx = 4'd9;

	// clocks spent in the current bit
	logic [cnt_bits-1:0] bit_cnt;

	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;

	// data bits with the stop bit parked on top
	logic [8:0] shift_reg;

	logic busy;
	logic bit_end;
	logic launch;

	assign bit_end = busy && (bit_cnt == cnt_last);

	// start when idle or right as a stop bit ends
	// so bytes go out back to back
	assign launch = tx_enable && byte_ready
		&& (!busy || (bit_end && bit_idx == stop_idx));

	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			busy      <= 1'b0;
			byte_take <= 1'b0;
			uart_tx   <= 1'b1;
			bit_cnt   <= '0;
			bit_idx   <= '0;
		end else begin
			// take lands in the first cycle of the start bit
			byte_take <= launch;
			if (launch) begin
				busy    <= 1'b1;
				uart_tx <= 1'b0;
				bit_cnt <= '0;
				bit_idx <= '0;
			end else if (busy) begin
				if (bit_end) begin
					bit_cnt <= '0;
					if (bit_idx == stop_idx) begin
						// line already high from the stop bit
						busy <= 1'b0;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						uart_tx <= shift_reg[0];
					end
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// lsb first, ones fill in behind
	always_ff @(posedge clk_pixel) begin
		if (launch) begin
			shift_reg <= {1'b1, frame_byte};
		end else if (bit_end && bit_idx != stop_idx) begin
			shift_reg <= {1'b1, shift_reg[8:1]};
		end
	end

endmodule

// File: src/frame_window_buffer.sv
`timescale 1ns/1ns

module frame_window_buffer #(
	parameter int window = speech_pkg::default_window,
	parameter int hop    = speech_pkg::default_hop
) (
	input  logic                     clk_pixel,
	input  logic                     sys_rst,
	input  speech_pkg::stream_byte_t emph_byte,
	input  logic                     emph_valid,
	input  logic                     byte_take,
	output speech_pkg::stream_byte_t frame_byte,
	output logic                     byte_ready
);

	// one window plus one hop of slack
	localparam int depth     = window + hop;
	localparam int addr_bits = $clog2(depth);
	localparam int left_bits = $clog2(window + 1);

	localparam logic [addr_bits-1:0] last_addr = addr_bits'(depth - 1);
	localparam logic [addr_bits-1:0] win_last  = addr_bits'(window - 1);
	localparam logic [addr_bits-1:0] hop_last  = addr_bits'(hop - 1);

	// oldest slot of a frame sits hop+1 past the newest one
	localparam logic [addr_bits:0] start_gap = (addr_bits + 1)'(hop + 1);
	localparam logic [addr_bits:0] wrap_sum  = (addr_bits + 1)'(depth);

	speech_pkg::stream_byte_t store [0:depth-1];

	logic [addr_bits-1:0] wr_addr;
	logic [addr_bits-1:0] rd_addr;
	logic [addr_bits-1:0] rd_addr_next;
	logic [addr_bits-1:0] fill_cnt;
	logic                 primed;
	logic [left_bits-1:0] rd_left;
	logic                 frame_due;
	logic [addr_bits:0]   start_sum;
	logic [addr_bits-1:0] start_addr;

	always_comb begin
		// first frame after a full window, then every hop
		frame_due = emph_valid && (fill_cnt == (primed ? hop_last : win_last));
		start_sum = {1'b0, wr_addr} + start_gap;
		if (start_sum >= wrap_sum) begin
			start_addr = addr_bits'(start_sum - wrap_sum);
		end else begin
			start_addr = start_sum[addr_bits-1:0];
		end
		rd_addr_next = (rd_addr == last_addr) ? '0 : rd_addr + 1'b1;
	end

	// sample store
	// writes never stall, even during a readout
	always_ff @(posedge clk_pixel) begin
		if (emph_valid) begin
			store[wr_addr] <= emph_byte;
		end
	end

	// write pointer and hop counter
	// a skipped frame still restarts the hop count
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			wr_addr  <= '0;
			fill_cnt <= '0;
			primed   <= 1'b0;
		end else if (emph_valid) begin
			wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;
			if (frame_due) begin
				fill_cnt <= '0;
				primed   <= 1'b1;
			end else begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	// readout sequencer
	// byte_ready doubles as the readout busy flag
	// a due count while busy is dropped here
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			byte_ready <= 1'b0;
			rd_addr    <= '0;
			rd_left    <= '0;
		end else if (frame_due && !byte_ready) begin
			byte_ready <= 1'b1;
			rd_addr    <= start_addr;
			rd_left    <= left_bits'(window);
		end else if (byte_ready && byte_take) begin
			if (rd_left == '0) begin
				// last sample gone
				byte_ready <= 1'b0;
			end else begin
				rd_addr <= rd_addr_next;
				rd_left <= rd_left - 1'b1;
			end
		end
	end

	// presented byte
	// marker first, then oldest to newest
	// only changes on the edge after a take
	always_ff @(posedge clk_pixel) begin
		if (frame_due && !byte_ready) begin
			frame_byte <= speech_pkg::frame_marker;
		end else if (byte_ready && byte_take && rd_left != '0) begin
			frame_byte <= store[rd_addr];
		end
	end

endmodule

// File: src/speech_conditioner.sv
`timescale 1ns/1ns

module speech_conditioner (
	input  logic                            clk_pixel,
	input  logic                            sys_rst,
	input  logic [speech_pkg::adc_bits-1:0] adc_code,
	input  logic                            adc_valid,
	output speech_pkg::stream_byte_t        emph_byte,
	output logic                            emph_valid
);

	localparam int sb = speech_pkg::sample_bits;
	localparam int pad_bits = sb - speech_pkg::adc_bits;

	// incoming code moved to the top of the word
	logic signed [sb-1:0] s_in;

	// stage one state
	// s_last holds s(n), which is s(n-1) for the next strobe
	logic signed [sb-1:0] s_last;
	logic signed [sb-1:0] o_cur;
	logic signed [sb-1:0] o_prev;
	logic                 stage1_valid;

	// offset compensated value for the incoming code
	logic signed [sb-1:0] o_next;

	// pre-emphasis result from stage one registers
	logic signed [sb-1:0] e_val;

	assign s_in = {adc_code, {pad_bits{1'b0}}};

	// o(n) = s(n) - s(n-1) + o(n-1) - o(n-1)/1024
	assign o_next = s_in - s_last + o_cur - (o_cur >>> speech_pkg::offset_shift);

	// e(n) = o(n) - o(n-1) + o(n-1)/32
	assign e_val = o_cur - o_prev + (o_prev >>> speech_pkg::emphasis_shift);

	// stage one
	// only moves on a strobe so the filter state tracks samples, not clocks
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			s_last       <= '0;
			o_cur        <= '0;
			o_prev       <= '0;
			stage1_valid <= 1'b0;
		end else begin
			stage1_valid <= adc_valid;
			if (adc_valid) begin
				s_last <= s_in;
				o_cur  <= o_next;
				o_prev <= o_cur;
			end
		end
	end

	// stage two
	// top byte of e(n), sign bit flipped to offset binary
	// a new strobe in stage one does not disturb this read
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			emph_byte  <= '0;
			emph_valid <= 1'b0;
		end else begin
			emph_valid <= stage1_valid;
			if (stage1_valid) begin
				emph_byte <= e_val[sb-1 -: 8] ^ 8'h80;
			end
		end
	end

endmodule

// File: src/speech_pkg.sv
package speech_pkg;

	// raw converter code width
	localparam int adc_bits = 10;

	// internal signed sample width
	// codes sit in the top bits
	localparam int sample_bits = 32;

	// one byte on the serial stream
	typedef logic [7:0] stream_byte_t;

	// 25 ms window at 16 kHz
	localparam int default_window = 400;

	// 10 ms hop at 16 kHz
	localparam int default_hop = 160;

	// sync byte ahead of every frame
	localparam stream_byte_t frame_marker = 8'hFF;

	// clocks per uart bit
	localparam int default_cycles_per_bit = 160;

	// leak of the offset filter, roughly 1/1000
	localparam int offset_shift = 10;

	// pre-emphasis term of 1/32
	localparam int emphasis_shift = 5;

endpackage
